//--- include/zx_settings.svh
//==========================================================================
// Bus block widths and port map
//==========================================================================

`ifndef ZX_SETTINGS_SVH
`define ZX_SETTINGS_SVH

// CPU side bus
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// Banked RAM of 16 banks by 16K
`define ZX_RAM_ADDR_W 18
`define ZX_BANK_W 4
`define ZX_BANK_OFS_W 14

// Scorpion extended paging port
`define ZX_PORT_EXT 16'h1FFD

// Banks fixed at 4000 and 8000
`define ZX_BANK_SLOT1 5
`define ZX_BANK_SLOT2 2

`endif

//--- logic/zx_pkg.sv
//==========================================================================
// Machine and port types
//==========================================================================

`default_nettype none

package zx_pkg;

	// Machine model, chosen at reset
	typedef enum logic [1:0] {
		MACH_SPEC128  = 2'd0,
		MACH_PENT256  = 2'd1,
		MACH_SCORP256 = 2'd2,
		MACH_SPEC48   = 2'd3
	} machine_t;

	// Decoded port write, valid for one clock
	typedef enum logic [1:0] {
		IO_NONE    = 2'd0,
		IO_PAGE_WR = 2'd1,
		IO_EXT_WR  = 2'd2,
		IO_ULA_WR  = 2'd3
	} io_op_t;

endpackage

`default_nettype wire

//--- logic/bank_ram.sv
//==========================================================================
// Single-port RAM
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

module bank_ram #(
	parameter int addr_w = 10,
	parameter int data_w = 8
) (
	input  logic              clk_sys,
	input  logic [addr_w-1:0] addr,
	input  logic [data_w-1:0] wdata,
	input  logic              we,
	output logic [data_w-1:0] q
);

	logic [data_w-1:0] mem [0:(1 << addr_w) - 1];

	// Registered read returns old data on a write cycle
	always_ff @(posedge clk_sys) begin
		if (we)
			mem[addr] <= wdata;
		q <= mem[addr];
	end

endmodule

`default_nettype wire

//--- logic/io_decoder.sv
//==========================================================================
// I/O write decoder
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "zx_settings.svh"

module io_decoder
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] wdata,
	input  logic                  iorq,
	input  logic                  wr,
	input  logic                  m1,
	output io_op_t                io_op,
	output logic [`ZX_DATA_W-1:0] io_data
);

	// Port write, interrupt acknowledge excluded
	logic   io_wr;
	logic   old_wr;
	io_op_t port_op;

	assign io_wr = iorq & wr & ~m1;

	// Extended port checked first since it also matches the paging pattern
	always_comb begin
		if (addr == `ZX_PORT_EXT)
			port_op = IO_EXT_WR;
		else if (!addr[15] && !addr[1])
			port_op = IO_PAGE_WR;
		else if (!addr[0])
			port_op = IO_ULA_WR;
		else
			port_op = IO_NONE;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr <= 1'b0;
			io_op  <= IO_NONE;
		end else begin
			old_wr <= io_wr;
			io_op  <= (io_wr && !old_wr) ? port_op : IO_NONE;
		end
	end

	// Data is captured with the operation
	always_ff @(posedge clk_sys) begin
		if (io_wr && !old_wr)
			io_data <= wdata;
	end

	// Pager samples the address while the operation is valid
	a_write_held: assert property (@(posedge clk_sys) disable iff (reset)
		(io_op != IO_NONE) |-> io_wr)
		else $error("port write strobe dropped before the operation was taken");

endmodule

`default_nettype wire

//--- logic/page_control.sv
//==========================================================================
// 128K paging register
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "zx_settings.svh"

module page_control
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  machine_t              machine_sel,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  io_op_t                io_op,
	input  logic [`ZX_DATA_W-1:0] io_data,
	output logic [`ZX_BANK_W-1:0] bank_top,
	output logic                  ram0,
	output logic                  screen_page,
	output logic [1:0]            rom_page
);

	machine_t machine;
	logic     zx48;
	logic     scorp;
	logic     page_lock;
	logic     page_disable;
	logic     page_take;
	logic     ext_take;
	// Bits 2..0 bank, 3 screen, 4 ROM, 5 lock
	logic [5:0] page_reg;
	logic       page_ext;

	assign zx48         = (machine == MACH_SPEC48);
	assign scorp        = (machine == MACH_SCORP256);
	assign page_lock    = page_reg[5];
	assign page_disable = zx48 | page_lock;

	// Scorpion also wants A14 high on the paging port
	assign page_take = (io_op == IO_PAGE_WR) && !page_disable && (addr[14] || !scorp);
	assign ext_take  = (io_op == IO_EXT_WR) && scorp && !page_disable;

	// Machine type only follows the selection while in reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			machine <= machine_sel;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg <= '0;
			page_ext <= 1'b0;
			ram0     <= 1'b0;
		end else if (page_take) begin
			page_reg <= io_data[5:0];
			if (machine == MACH_PENT256)
				page_ext <= io_data[6];
		end else if (ext_take) begin
			page_ext <= io_data[4];
			ram0     <= io_data[0];
		end
	end

	//==========================================================================
	// Outputs
	//==========================================================================

	assign bank_top    = {page_ext, page_reg[2:0]};
	assign screen_page = page_reg[3];
	// 3 is 48 BASIC, 2 is the 128 editor
	assign rom_page    = (zx48 || page_reg[4]) ? 2'd3 : 2'd2;

	// Lock only clears through reset
	a_lock_hold: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(page_lock) |-> $past(reset))
		else $error("paging lock cleared without reset");

endmodule

`default_nettype wire

//--- logic/mem_map.sv
//==========================================================================
// CPU address to RAM bank mapping
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "zx_settings.svh"

module mem_map (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic [`ZX_ADDR_W-1:0]     addr,
	input  logic [`ZX_DATA_W-1:0]     wdata,
	input  logic                      mreq,
	input  logic                      rd,
	input  logic                      wr,
	input  logic [`ZX_BANK_W-1:0]     bank_top,
	input  logic                      ram0,
	input  logic [`ZX_DATA_W-1:0]     ram_q,
	output logic [`ZX_RAM_ADDR_W-1:0] ram_addr,
	output logic [`ZX_DATA_W-1:0]     ram_wdata,
	output logic                      ram_we,
	output logic [`ZX_DATA_W-1:0]     rdata
);

	localparam logic [`ZX_BANK_W-1:0] slot1_bank = `ZX_BANK_SLOT1;
	localparam logic [`ZX_BANK_W-1:0] slot2_bank = `ZX_BANK_SLOT2;

	logic [`ZX_BANK_W-1:0] bank;
	logic                  ram_sel;
	logic                  mem_wr;
	logic                  old_wr;
	logic                  rd_ram;

	// Slot 0 is ROM unless ram0 is set
	assign ram_sel = (addr[15:14] != 2'b00) | ram0;
	assign mem_wr  = mreq & wr & ram_sel;

	always_comb begin
		case (addr[15:14])
			2'd0:    bank = '0;
			2'd1:    bank = slot1_bank;
			2'd2:    bank = slot2_bank;
			default: bank = bank_top;
		endcase
	end

	assign ram_addr  = {bank, addr[`ZX_BANK_OFS_W-1:0]};
	assign ram_wdata = wdata;

	// One write per bus cycle, on the strobe edge
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_wr <= 1'b0;
			ram_we <= 1'b0;
			rd_ram <= 1'b0;
		end else begin
			old_wr <= mem_wr;
			ram_we <= mem_wr & ~old_wr;
			rd_ram <= mreq & rd & ram_sel;
		end
	end

	// Unmapped reads float high
	assign rdata = rd_ram ? ram_q : {`ZX_DATA_W{1'b1}};

	a_rom_protect: assert property (@(posedge clk_sys) disable iff (reset)
		ram_we |-> (addr[15:14] != 2'b00) || ram0)
		else $error("RAM write into slot 0 while ROM is mapped");

endmodule

`default_nettype wire

//--- logic/ula_port.sv
//==========================================================================
// ULA output port
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "zx_settings.svh"

module ula_port
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  io_op_t                io_op,
	input  logic [`ZX_DATA_W-1:0] io_data,
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic
);

	logic ula_wr;

	assign ula_wr = (io_op == IO_ULA_WR);

	// Border colour survives reset
	always_ff @(posedge clk_sys) begin
		if (ula_wr)
			border <= io_data[2:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ear <= 1'b0;
			mic <= 1'b0;
		end else if (ula_wr) begin
			ear <= io_data[4];
			mic <= io_data[3];
		end
	end

endmodule

`default_nettype wire

//--- logic/zx_bus_top.sv
//==========================================================================
// Spectrum paging and port block
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

`include "zx_settings.svh"

module zx_bus_top
	import zx_pkg::*;
(
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] wdata,
	input  logic                  mreq,
	input  logic                  iorq,
	input  logic                  rd,
	input  logic                  wr,
	input  logic                  m1,
	input  machine_t              machine_sel,
	output logic [`ZX_DATA_W-1:0] rdata,
	output logic [1:0]            rom_page,
	output logic                  screen_page,
	output logic [2:0]            border,
	output logic                  ear,
	output logic                  mic
);

	io_op_t                    io_op;
	logic [`ZX_DATA_W-1:0]     io_data;
	logic [`ZX_BANK_W-1:0]     bank_top;
	logic                      ram0;
	logic [`ZX_RAM_ADDR_W-1:0] ram_addr;
	logic [`ZX_DATA_W-1:0]     ram_wdata;
	logic                      ram_we;
	logic [`ZX_DATA_W-1:0]     ram_q;

	//==========================================================================
	// Port side
	//==========================================================================

	io_decoder u_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.addr    (addr),
		.wdata   (wdata),
		.iorq    (iorq),
		.wr      (wr),
		.m1      (m1),
		.io_op   (io_op),
		.io_data (io_data)
	);

	page_control u_pager (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.machine_sel (machine_sel),
		.addr        (addr),
		.io_op       (io_op),
		.io_data     (io_data),
		.bank_top    (bank_top),
		.ram0        (ram0),
		.screen_page (screen_page),
		.rom_page    (rom_page)
	);

	ula_port u_ula (
		.clk_sys (clk_sys),
		.reset   (reset),
		.io_op   (io_op),
		.io_data (io_data),
		.border  (border),
		.ear     (ear),
		.mic     (mic)
	);

	//==========================================================================
	// Memory side
	//==========================================================================

	mem_map u_mapper (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.mreq      (mreq),
		.rd        (rd),
		.wr        (wr),
		.bank_top  (bank_top),
		.ram0      (ram0),
		.ram_q     (ram_q),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_we    (ram_we),
		.rdata     (rdata)
	);

	bank_ram #(
		.addr_w (`ZX_RAM_ADDR_W),
		.data_w (`ZX_DATA_W)
	) u_ram (
		.clk_sys (clk_sys),
		.addr    (ram_addr),
		.wdata   (ram_wdata),
		.we      (ram_we),
		.q       (ram_q)
	);

endmodule

`default_nettype wire

//--- tests/tb_zx_bus.sv
//==========================================================================
// Paging and port block testbench
//==========================================================================

`timescale 1ns/10ps
`default_nettype none

module tb_zx_bus
	import zx_pkg::*;
();

	typedef enum logic [2:0] {
		OP_RESET,
		OP_MEM_WR,
		OP_MEM_RD,
		OP_IO_WR,
		OP_CHECK
	} step_op_t;

	localparam int clk_half    = 10;
	// Longest step is a bus cycle with its idle gap
	localparam int step_clocks = 6;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  wdata;
	logic        mreq;
	logic        iorq;
	logic        rd;
	logic        wr;
	logic        m1;
	machine_t    machine_sel;
	logic [7:0]  rdata;
	logic [1:0]  rom_page;
	logic        screen_page;
	logic [2:0]  border;
	logic        ear;
	logic        mic;

	// Step table
	string       step_name[$];
	machine_t    step_mach[$];
	step_op_t    step_op[$];
	logic [15:0] step_addr[$];
	logic [7:0]  step_data[$];
	logic [7:0]  step_exp[$];
	bit          table_ready = 1'b0;

	int checks;
	int errors;
	int tests;

	// Reference model of the paging state and RAM contents
	machine_t   m_mach;
	logic [5:0] m_reg;
	logic       m_ext;
	logic       m_ram0;
	logic [7:0] shadow [int];

	always #(clk_half) clk_sys = ~clk_sys;

	zx_bus_top UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.addr        (addr),
		.wdata       (wdata),
		.mreq        (mreq),
		.iorq        (iorq),
		.rd          (rd),
		.wr          (wr),
		.m1          (m1),
		.machine_sel (machine_sel),
		.rdata       (rdata),
		.rom_page    (rom_page),
		.screen_page (screen_page),
		.border      (border),
		.ear         (ear),
		.mic         (mic)
	);

	//==========================================================================
	// Model
	//==========================================================================

	task automatic reset_model(input machine_t mach);
		m_mach = mach;
		m_reg  = '0;
		m_ext  = 1'b0;
		m_ram0 = 1'b0;
	endtask

	task automatic track_io_write(input logic [15:0] a, input logic [7:0] d);
		if (a == 16'h1FFD) begin
			if (m_mach == MACH_SCORP256 && !m_reg[5]) begin
				m_ext  = d[4];
				m_ram0 = d[0];
			end
		end else if (!a[15] && !a[1]) begin
			// Scorpion decodes A14 as well
			if (m_mach != MACH_SPEC48 && !m_reg[5] && (a[14] || m_mach != MACH_SCORP256)) begin
				m_reg = d[5:0];
				if (m_mach == MACH_PENT256)
					m_ext = d[6];
			end
		end
	endtask

	task automatic map_address(input logic [15:0] a, output logic mapped,
			output logic [17:0] ra);
		logic [3:0] bank;
		mapped = 1'b1;
		case (a[15:14])
			2'd0: begin
				bank   = 4'd0;
				mapped = m_ram0;
			end
			2'd1:    bank = 4'd5;
			2'd2:    bank = 4'd2;
			default: bank = {m_ext, m_reg[2:0]};
		endcase
		ra = {bank, a[13:0]};
	endtask

	//==========================================================================
	// Bus driving and checks
	//==========================================================================

	task automatic apply_reset(input machine_t mach);
		@(negedge clk_sys);
		machine_sel = mach;
		reset = 1'b1;
		repeat (2) @(negedge clk_sys);
		reset = 1'b0;
		reset_model(mach);
	endtask

	// Strobes held three clocks, then two idle clocks
	task automatic bus_cycle(input logic is_io, input logic is_wr, input logic [15:0] a,
			input logic [7:0] d, output logic [7:0] got);
		@(negedge clk_sys);
		addr  = a;
		wdata = d;
		mreq  = !is_io;
		iorq  = is_io;
		rd    = !is_wr;
		wr    = is_wr;
		@(negedge clk_sys);
		got = rdata;
		repeat (2) @(negedge clk_sys);
		mreq = 1'b0;
		iorq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic check_value(input string name, input logic [7:0] exp,
			input logic [7:0] got);
		checks++;
		assert (got === exp)
		else begin
			$display("ERR %s: expected %02h, actual %02h", name, exp, got);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		tests++;
		if (errs == 0)
			$display("%-10s ok", name);
		else
			$display("%-10s failed with %0d errors", name, errs);
	endtask

	task automatic add_step(input string name, input machine_t mach, input step_op_t op,
			input logic [15:0] a, input logic [7:0] d, input logic [7:0] exp);
		step_name.push_back(name);
		step_mach.push_back(mach);
		step_op.push_back(op);
		step_addr.push_back(a);
		step_data.push_back(d);
		step_exp.push_back(exp);
	endtask

	//==========================================================================
	// Step table
	//==========================================================================

	// Checked outputs pack as {rom_page, screen_page, border, ear, mic}
	task automatic build_table;
		add_step("reset", MACH_SPEC128, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("reset", MACH_SPEC128, OP_IO_WR, 16'h00FE, 8'h19, 8'h00);
		add_step("reset", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h08, 8'h00);
		add_step("reset", MACH_SPEC128, OP_CHECK, 16'h0000, 8'h00, 8'hA7);
		add_step("reset", MACH_SPEC48, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("reset", MACH_SPEC48, OP_CHECK, 16'h0000, 8'h00, 8'hC4);
		add_step("reset", MACH_SPEC48, OP_IO_WR, 16'h00FE, 8'h19, 8'h00);
		add_step("reset", MACH_PENT256, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("reset", MACH_PENT256, OP_CHECK, 16'h0000, 8'h00, 8'h84);
		add_step("reset", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h18, 8'h00);
		add_step("reset", MACH_PENT256, OP_IO_WR, 16'h00FE, 8'h19, 8'h00);
		add_step("reset", MACH_SCORP256, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("reset", MACH_SCORP256, OP_CHECK, 16'h0000, 8'h00, 8'h84);
		add_step("reset", MACH_SCORP256, OP_IO_WR, 16'h7FFD, 8'h18, 8'h00);
		add_step("reset", MACH_SCORP256, OP_IO_WR, 16'h00FE, 8'h19, 8'h00);
		add_step("reset", MACH_SPEC128, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("reset", MACH_SPEC128, OP_CHECK, 16'h0000, 8'h00, 8'h84);
		// Fill several banks through slot 3 and the fixed slots
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h01, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h03, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h07, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'hFFFF, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'h4000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_WR, 16'h8001, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h01, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h03, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h07, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hFFFF, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h05, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'h4000, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h02, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'hC001, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_MEM_RD, 16'h8001, 8'h00, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h08, 8'h00);
		add_step("paging128", MACH_SPEC128, OP_CHECK, 16'h0000, 8'h00, 8'hA4);
		// Locked register ignores page writes until reset
		add_step("lock", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h21, 8'h00);
		add_step("lock", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC128, OP_IO_WR, 16'h7FFD, 8'h13, 8'h00);
		add_step("lock", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC128, OP_CHECK, 16'h0000, 8'h00, 8'h84);
		add_step("lock", MACH_SPEC128, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC128, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC48, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC48, OP_IO_WR, 16'h7FFD, 8'h03, 8'h00);
		add_step("lock", MACH_SPEC48, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("lock", MACH_SPEC48, OP_CHECK, 16'h0000, 8'h00, 8'hC4);
		// Pentagon bit 6 reaches banks 8 to 15
		add_step("pent_ext", MACH_PENT256, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h40, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h41, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h40, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_IO_WR, 16'h7FFD, 8'h41, 8'h00);
		add_step("pent_ext", MACH_PENT256, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		// Scorpion extended port, A14 decode and RAM at slot 0
		add_step("scorp_ext", MACH_SCORP256, OP_RESET, 16'h0000, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h1FFD, 8'h10, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h7FFD, 8'h02, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_WR, 16'hC000, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h1FFD, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'hC001, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h1FFD, 8'h10, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h3FFD, 8'h03, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'hC000, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'h0000, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_WR, 16'h0010, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'h0010, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h1FFD, 8'h11, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_WR, 16'h0010, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'h0010, 8'h00, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_IO_WR, 16'h1FFD, 8'h10, 8'h00);
		add_step("scorp_ext", MACH_SCORP256, OP_MEM_RD, 16'h0010, 8'h00, 8'h00);
		// Border, ear and mic stay put across a paging write
		add_step("ula", MACH_SCORP256, OP_IO_WR, 16'h00FE, 8'h05, 8'h00);
		add_step("ula", MACH_SCORP256, OP_CHECK, 16'h0000, 8'h00, 8'h94);
		add_step("ula", MACH_SCORP256, OP_IO_WR, 16'h00FE, 8'h1A, 8'h00);
		add_step("ula", MACH_SCORP256, OP_CHECK, 16'h0000, 8'h00, 8'h8B);
		add_step("ula", MACH_SCORP256, OP_IO_WR, 16'h7FFD, 8'h0A, 8'h00);
		add_step("ula", MACH_SCORP256, OP_CHECK, 16'h0000, 8'h00, 8'hAB);
		add_step("ula", MACH_SCORP256, OP_IO_WR, 16'h00FE, 8'h17, 8'h00);
		add_step("ula", MACH_SCORP256, OP_CHECK, 16'h0000, 8'h00, 8'hBE);
	endtask

	//==========================================================================
	// Main sequence
	//==========================================================================

	initial begin
		logic [7:0]  got;
		logic [7:0]  data;
		logic [17:0] ra;
		logic        mapped;
		string       cur;
		int          test_start;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		addr        = '0;
		wdata       = '0;
		mreq        = 1'b0;
		iorq        = 1'b0;
		rd          = 1'b0;
		wr          = 1'b0;
		m1          = 1'b0;
		machine_sel = MACH_SPEC128;
		checks      = 0;
		errors      = 0;
		tests       = 0;
		void'($urandom(43294));
		build_table();
		table_ready = 1'b1;
		cur         = step_name[0];
		test_start  = 0;
		foreach (step_op[i]) begin
			if (step_name[i] != cur) begin
				report_test(cur, errors - test_start);
				cur        = step_name[i];
				test_start = errors;
			end
			case (step_op[i])
				OP_RESET: apply_reset(step_mach[i]);
				OP_MEM_WR: begin
					data = 8'($urandom);
					bus_cycle(1'b0, 1'b1, step_addr[i], data, got);
					map_address(step_addr[i], mapped, ra);
					if (mapped)
						shadow[int'(ra)] = data;
				end
				OP_MEM_RD: begin
					bus_cycle(1'b0, 1'b0, step_addr[i], 8'h00, got);
					map_address(step_addr[i], mapped, ra);
					// ROM region reads back all ones
					if (!mapped)
						check_value(step_name[i], 8'hFF, got);
					else if (shadow.exists(int'(ra)))
						check_value(step_name[i], shadow[int'(ra)], got);
					else begin
						$display("%s: RAM address %05h was read before any write", step_name[i], ra);
						errors++;
					end
				end
				OP_IO_WR: begin
					bus_cycle(1'b1, 1'b1, step_addr[i], step_data[i], got);
					track_io_write(step_addr[i], step_data[i]);
				end
				default: begin
					@(negedge clk_sys);
					check_value(step_name[i], step_exp[i],
						{rom_page, screen_page, border, ear, mic});
				end
			endcase
		end
		report_test(cur, errors - test_start);
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog sized from the step table
	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = step_name.size() * step_clocks * 2 * clk_half * 2;
		#(limit_ns);
		$display("run timed out after %0d ns before the step table finished", limit_ns);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
logic/zx_pkg.sv
logic/bank_ram.sv
logic/io_decoder.sv
logic/page_control.sv
logic/mem_map.sv
logic/ula_port.sv
logic/zx_bus_top.sv
tests/tb_zx_bus.sv

//--- Makefile
# Verilator build for the paging and port block

TOP = tb_zx_bus

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
